// File: design/pcxt_pkg.sv
/* Shared timing constants, rates, DIP values and state types for the PC/XT control glue.
   Every design and testbench file refers to these through pcxt_pkg:: scoped names. */

`default_nettype none

package pcxt_pkg;

	//////////////////////////////////////////////////
	// Rates
	//////////////////////////////////////////////////

	// Accumulator width, wide enough for clock_hz plus the largest step
	typedef logic [31:0] acc_t;

	// Master clock frequency
	localparam acc_t clock_hz = 32'd50_000_000;

	// Audio sample enable, 44.1 kHz
	localparam acc_t audio_step = 32'd44_100;

	// CPU enables, 4.77, 7.16 and 14.318 MHz
	localparam acc_t cpu_step_normal = 32'd4_772_727;
	localparam acc_t cpu_step_7m     = 32'd7_159_090;
	localparam acc_t cpu_step_14m    = 32'd14_318_180;

	//////////////////////////////////////////////////
	// Reset timing
	//////////////////////////////////////////////////

	// System reset hold, in CLK_50M cycles
	localparam logic [15:0] reset_hold_cycles = 16'd65535;

	// CPU reset release after system reset release
	localparam logic [15:0] cpu_reset_delay = 16'd42;

	//////////////////////////////////////////////////
	// DIP switches
	//////////////////////////////////////////////////

	// Color display, 80 columns
	localparam logic [7:0] dip_sw_cga = 8'h2D;
	// Monochrome display
	localparam logic [7:0] dip_sw_mda = 8'h3D;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	// CPU clock selection
	typedef enum logic [1:0] {
		SPEED_4M77,
		SPEED_7M16,
		SPEED_14M318
	} cpu_speed_t;

	// Reset sequencer states
	typedef enum logic [1:0] {
		RST_HOLD,
		RST_CPU_WAIT,
		RST_RUN
	} reset_state_t;

endpackage

`default_nettype wire

// File: design/reset_sequencer.sv
/* Merges power-on and menu, button and BIOS-load reset requests, then releases
   the system reset after a long hold and the CPU reset a short delay later. */

`default_nettype none

module reset_sequencer (
	input  wire  CLK_50M,
	input  wire  reset_wire,
	input  wire  menu_reset,
	input  wire  user_button,
	input  wire  bios_loading,
	output logic sys_reset,
	output logic cpu_reset
);

	pcxt_pkg::reset_state_t state;
	pcxt_pkg::reset_state_t state_next;
	logic [15:0] count;
	logic [15:0] count_next;
	logic        request;

	// Any synchronous request restarts the whole sequence
	assign request = menu_reset | user_button | bios_loading;

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		count_next = count + 16'd1;
		if (request) begin
			state_next = pcxt_pkg::RST_HOLD;
			count_next = '0;
		end else begin
			case (state)
				pcxt_pkg::RST_HOLD: begin
					// Last hold cycle, hand over to the CPU delay
					if (count == pcxt_pkg::reset_hold_cycles - 16'd1) begin
						state_next = pcxt_pkg::RST_CPU_WAIT;
						count_next = '0;
					end
				end
				pcxt_pkg::RST_CPU_WAIT: begin
					if (count == pcxt_pkg::cpu_reset_delay - 16'd1) begin
						state_next = pcxt_pkg::RST_RUN;
						count_next = '0;
					end
				end
				pcxt_pkg::RST_RUN: begin
					// Counter parked while running
					count_next = count;
				end
				default: begin
					// Unused encoding, restart the sequence
					state_next = pcxt_pkg::RST_HOLD;
					count_next = '0;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// State and output registers
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			state     <= pcxt_pkg::RST_HOLD;
			count     <= '0;
			sys_reset <= 1'b1;
			cpu_reset <= 1'b1;
		end else begin
			state     <= state_next;
			count     <= count_next;
			// Outputs follow the state being entered
			sys_reset <= (state_next == pcxt_pkg::RST_HOLD);
			cpu_reset <= (state_next != pcxt_pkg::RST_RUN);
		end
	end

endmodule

`default_nettype wire

// File: design/clock_enables.sv
/* Fractional-rate clock enables for audio and CPU, plus the CPU speed latch.
   The speed only changes at a bus-done strobe so a CPU bus cycle is never cut short. */

`default_nettype none

module clock_enables (
	input  wire                  CLK_50M,
	input  wire                  sys_reset,
	input  pcxt_pkg::cpu_speed_t cpu_speed,
	input  wire                  bus_done,
	output logic                 audio_ce,
	output logic                 cpu_ce,
	output logic                 turbo_mode
);

	pcxt_pkg::acc_t       audio_acc;
	pcxt_pkg::acc_t       cpu_acc;
	pcxt_pkg::acc_t       cpu_step;
	pcxt_pkg::cpu_speed_t speed_q;
	logic [32:0]          audio_next;
	logic [32:0]          cpu_next;

	// One accumulator step
	// Bit 32 is the enable, the rest the new accumulator value
	function automatic logic [32:0] frac_next(
		input pcxt_pkg::acc_t acc,
		input pcxt_pkg::acc_t step
	);
		pcxt_pkg::acc_t sum;
		sum = acc + step;
		if (sum >= pcxt_pkg::clock_hz)
			frac_next = {1'b1, sum - pcxt_pkg::clock_hz};
		else
			frac_next = {1'b0, sum};
	endfunction

	//////////////////////////////////////////////////
	// Step selection
	//////////////////////////////////////////////////

	// Driven by the latched speed, never the live menu value
	always_comb begin
		case (speed_q)
			pcxt_pkg::SPEED_7M16:   cpu_step = pcxt_pkg::cpu_step_7m;
			pcxt_pkg::SPEED_14M318: cpu_step = pcxt_pkg::cpu_step_14m;
			default:                cpu_step = pcxt_pkg::cpu_step_normal;
		endcase
	end

	assign audio_next = frac_next(audio_acc, pcxt_pkg::audio_step);
	assign cpu_next   = frac_next(cpu_acc, cpu_step);

	// Anything faster than stock counts as turbo
	assign turbo_mode = (speed_q != pcxt_pkg::SPEED_4M77);

	//////////////////////////////////////////////////
	// Accumulators and speed latch
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge sys_reset) begin
		if (sys_reset) begin
			audio_acc <= '0;
			audio_ce  <= 1'b0;
			cpu_acc   <= '0;
			cpu_ce    <= 1'b0;
			speed_q   <= pcxt_pkg::SPEED_4M77;
		end else begin
			// Registered enables, one-cycle pulses
			audio_ce  <= audio_next[32];
			audio_acc <= audio_next[31:0];
			cpu_ce    <= cpu_next[32];
			cpu_acc   <= cpu_next[31:0];
			// New speed takes effect from the next edge
			if (bus_done)
				speed_q <= cpu_speed;
		end
	end

endmodule

`default_nettype wire

// File: design/core_config.sv
/* Combinational decode of the menu fields into video controls, CPU speed
   and the DIP-switch nibble seen on keyboard port C. */

`default_nettype none

module core_config (
	input  wire  [1:0]           aspect_ratio,
	input  wire  [1:0]           scale,
	input  wire                  mda_select,
	input  wire  [1:0]           speed_field,
	input  wire  [7:0]           port_b,
	output logic [12:0]          video_arx,
	output logic [12:0]          video_ary,
	output logic [1:0]           vga_sl,
	output logic                 scandoubler,
	output logic                 hq2x,
	output logic [3:0]           port_c_low,
	output pcxt_pkg::cpu_speed_t cpu_speed
);

	logic [7:0] dip_sw;
	logic [1:0] ar_minus;

	//////////////////////////////////////////////////
	// Video
	//////////////////////////////////////////////////

	assign ar_minus = aspect_ratio - 2'd1;

	// Original 4:3, otherwise full screen or one of the custom ratios
	assign video_arx = (aspect_ratio == 2'd0) ? 13'd4 : {11'd0, ar_minus};
	assign video_ary = (aspect_ratio == 2'd0) ? 13'd3 : 13'd0;

	// Scanline strength, 50% on scale 3, 25% on scale 2
	assign vga_sl      = {scale == 2'd3, scale == 2'd2};
	assign scandoubler = (scale != 2'd0);
	assign hq2x        = (scale == 2'd1);

	//////////////////////////////////////////////////
	// DIP switches
	//////////////////////////////////////////////////

	assign dip_sw = mda_select ? pcxt_pkg::dip_sw_mda : pcxt_pkg::dip_sw_cga;

	// Port B bit 3 picks which switch bank the BIOS reads
	assign port_c_low = port_b[3] ? dip_sw[7:4] : dip_sw[3:0];

	//////////////////////////////////////////////////
	// CPU speed
	//////////////////////////////////////////////////

	always_comb begin
		case (speed_field)
			2'd1:    cpu_speed = pcxt_pkg::SPEED_7M16;
			2'd2:    cpu_speed = pcxt_pkg::SPEED_14M318;
			// 0 and the unused code fall back to stock speed
			default: cpu_speed = pcxt_pkg::SPEED_4M77;
		endcase
	end

endmodule

`default_nettype wire

// File: design/pcxt_control.sv
/* System control top level for the PC/XT core: reset sequencing, clock enables
   and menu decode, all on CLK_50M. */

`default_nettype none

module pcxt_control (
	input  wire        CLK_50M,
	input  wire        reset_wire,
	input  wire        menu_reset,
	input  wire        user_button,
	input  wire        bios_loading,
	input  wire        bus_done,
	input  wire [1:0]  aspect_ratio,
	input  wire [1:0]  scale,
	input  wire        mda_select,
	input  wire [1:0]  speed_field,
	input  wire [7:0]  port_b,
	output wire        sys_reset,
	output wire        cpu_reset,
	output wire        audio_ce,
	output wire        cpu_ce,
	output wire        turbo_mode,
	output wire [12:0] video_arx,
	output wire [12:0] video_ary,
	output wire [1:0]  vga_sl,
	output wire        scandoubler,
	output wire        hq2x,
	output wire [3:0]  port_c_low
);

	// Menu speed, before the bus-done latch
	pcxt_pkg::cpu_speed_t cpu_speed;

	//////////////////////////////////////////////////
	// Reset
	//////////////////////////////////////////////////

	reset_sequencer u_reset_sequencer (
		.CLK_50M      (CLK_50M),
		.reset_wire   (reset_wire),
		.menu_reset   (menu_reset),
		.user_button  (user_button),
		.bios_loading (bios_loading),
		.sys_reset    (sys_reset),
		.cpu_reset    (cpu_reset)
	);

	//////////////////////////////////////////////////
	// Enables
	//////////////////////////////////////////////////

	// Held in reset along with the rest of the system
	clock_enables u_clock_enables (
		.CLK_50M    (CLK_50M),
		.sys_reset  (sys_reset),
		.cpu_speed  (cpu_speed),
		.bus_done   (bus_done),
		.audio_ce   (audio_ce),
		.cpu_ce     (cpu_ce),
		.turbo_mode (turbo_mode)
	);

	//////////////////////////////////////////////////
	// Menu decode
	//////////////////////////////////////////////////

	core_config u_core_config (
		.aspect_ratio (aspect_ratio),
		.scale        (scale),
		.mda_select   (mda_select),
		.speed_field  (speed_field),
		.port_b       (port_b),
		.video_arx    (video_arx),
		.video_ary    (video_ary),
		.vga_sl       (vga_sl),
		.scandoubler  (scandoubler),
		.hq2x         (hq2x),
		.port_c_low   (port_c_low),
		.cpu_speed    (cpu_speed)
	);

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
/* Testbench clock source: 50 MHz CLK_50M and a power-on reset held for 5 cycles. */

`default_nettype none

module tb_clock (
	output logic CLK_50M,
	output logic reset_wire
);

	timeunit 1ns;
	timeprecision 1ps;

	// 20 ns period
	always #10 CLK_50M = ~CLK_50M;

	initial begin
		CLK_50M    = 1'b0;
		reset_wire = 1'b1;
		// Release on a falling edge, away from the sampling edge
		repeat (5) @(negedge CLK_50M);
		reset_wire = 1'b0;
	end

endmodule

`default_nettype wire

// File: tb/pcxt_control_checker.sv
/* Concurrent assertions on the reset and enable outputs of the control top level.
   Attached to every pcxt_control instance through the bind at the end. */

`default_nettype none

module pcxt_control_checker (
	input wire CLK_50M,
	input wire reset_wire,
	input wire bus_done,
	input wire sys_reset,
	input wire cpu_reset,
	input wire audio_ce,
	input wire cpu_ce,
	input wire turbo_mode
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertion count
	int failures = 0;

	// CPU never leaves reset before the system
	cpu_reset_covers_sys: assert property (
		@(posedge CLK_50M) disable iff (reset_wire) sys_reset |-> cpu_reset)
		else begin
			failures++;
			$error("cpu_reset low while sys_reset is high");
		end

	// No enables while the system is held
	enables_quiet_in_reset: assert property (
		@(posedge CLK_50M) disable iff (reset_wire) sys_reset |-> (!audio_ce && !cpu_ce))
		else begin
			failures++;
			$error("clock enable active while sys_reset is high");
		end

	// Fastest CPU rate is below half the clock
	cpu_ce_single_pulse: assert property (
		@(posedge CLK_50M) disable iff (reset_wire) cpu_ce |=> !cpu_ce)
		else begin
			failures++;
			$error("cpu_ce high on two consecutive cycles");
		end

	// Speed latch only moves at the end of a bus cycle
	turbo_only_after_bus_done: assert property (
		@(posedge CLK_50M) disable iff (reset_wire || sys_reset)
		!bus_done |=> $stable(turbo_mode))
		else begin
			failures++;
			$error("turbo_mode changed without bus_done");
		end

endmodule

bind pcxt_control pcxt_control_checker u_checker (
	.CLK_50M    (CLK_50M),
	.reset_wire (reset_wire),
	.bus_done   (bus_done),
	.sys_reset  (sys_reset),
	.cpu_reset  (cpu_reset),
	.audio_ce   (audio_ce),
	.cpu_ce     (cpu_ce),
	.turbo_mode (turbo_mode)
);

`default_nettype wire

// File: tb/pcxt_control_tb.sv
/* Testbench for the PC/XT control glue: random stimulus checked every cycle
   against a reference model of the reset, clock-enable and decode rules. */

`default_nettype none

module pcxt_control_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// Four full reset sequences plus the random run, with margin
	localparam int timeout_cycles = 300000;
	localparam int random_cycles  = 20000;
	localparam int seq_len = int'(pcxt_pkg::reset_hold_cycles) + int'(pcxt_pkg::cpu_reset_delay);

	wire        CLK_50M;
	wire        reset_wire;
	logic       menu_reset;
	logic       user_button;
	logic       bios_loading;
	logic       bus_done;
	logic [1:0] aspect_ratio;
	logic [1:0] scale;
	logic       mda_select;
	logic [1:0] speed_field;
	logic [7:0] port_b;
	wire        sys_reset;
	wire        cpu_reset;
	wire        audio_ce;
	wire        cpu_ce;
	wire        turbo_mode;
	wire [12:0] video_arx;
	wire [12:0] video_ary;
	wire [1:0]  vga_sl;
	wire        scandoubler;
	wire        hq2x;
	wire [3:0]  port_c_low;

	// Model state
	int     elapsed       = 0;
	logic   m_sys         = 1'b1;
	logic   m_cpu         = 1'b1;
	logic   m_audio_ce    = 1'b0;
	logic   m_cpu_ce      = 1'b0;
	longint m_audio_acc   = 0;
	longint m_cpu_acc     = 0;
	int     m_speed       = 0;
	int     audio_updates = 0;
	// DUT audio pulses since the last reset release
	int     audio_pulses  = 0;
	int     cycle_count   = 0;

	tb_clock u_clock (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire)
	);

	pcxt_control dut (.*);

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("** FAIL **");
			$fatal(1, "Output %s does not match the model", name);
		end
	endtask

	////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////

	// Speed code 0 stock, 1 for 7.16 MHz, 2 for 14.318 MHz
	function automatic int speed_for(input logic [1:0] field);
		return (field == 2'd1) ? 1 : ((field == 2'd2) ? 2 : 0);
	endfunction

	function automatic longint step_for(input int speed);
		if (speed == 1)
			return pcxt_pkg::cpu_step_7m;
		else if (speed == 2)
			return pcxt_pkg::cpu_step_14m;
		return pcxt_pkg::cpu_step_normal;
	endfunction

	task automatic accumulate(inout longint acc, output logic ce, input longint step);
		acc = acc + step;
		ce  = (acc >= pcxt_pkg::clock_hz);
		if (ce)
			acc = acc - pcxt_pkg::clock_hz;
	endtask

	// One rising edge, using the inputs held since the last falling edge
	task automatic step_model();
		logic sys_before;
		sys_before = m_sys;
		if (menu_reset || user_button || bios_loading)
			elapsed = 0;
		else if (elapsed < seq_len)
			elapsed++;
		m_sys = (elapsed < int'(pcxt_pkg::reset_hold_cycles));
		m_cpu = (elapsed < seq_len);
		// Enables held for the whole edge on either side of a reset change
		if (sys_before || m_sys) begin
			m_audio_acc   = 0;
			m_cpu_acc     = 0;
			m_audio_ce    = 1'b0;
			m_cpu_ce      = 1'b0;
			m_speed       = 0;
			audio_updates = 0;
			audio_pulses  = 0;
		end else begin
			accumulate(m_audio_acc, m_audio_ce, pcxt_pkg::audio_step);
			accumulate(m_cpu_acc, m_cpu_ce, step_for(m_speed));
			audio_updates++;
			if (bus_done)
				m_speed = speed_for(speed_field);
		end
	endtask

	task automatic compare_outputs();
		logic [7:0] dip;
		dip = mda_select ? pcxt_pkg::dip_sw_mda : pcxt_pkg::dip_sw_cga;
		check_value("sys_reset", sys_reset, m_sys);
		check_value("cpu_reset", cpu_reset, m_cpu);
		check_value("audio_ce", audio_ce, m_audio_ce);
		audio_pulses += audio_ce;
		check_value("cpu_ce", cpu_ce, m_cpu_ce);
		check_value("turbo_mode", turbo_mode, m_speed != 0);
		// Menu decode, same cycle
		check_value("video_arx", video_arx, (aspect_ratio == 2'd0) ? 32'd4 : aspect_ratio - 32'd1);
		check_value("video_ary", video_ary, (aspect_ratio == 2'd0) ? 32'd3 : 32'd0);
		check_value("vga_sl", vga_sl, (scale == 2'd3) ? 32'd2 : ((scale == 2'd2) ? 32'd1 : 32'd0));
		check_value("scandoubler", scandoubler, scale != 2'd0);
		check_value("hq2x", hq2x, scale == 2'd1);
		check_value("port_c_low", port_c_low, port_b[3] ? dip[7:4] : dip[3:0]);
	endtask

	////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////

	// Request code 1 menu, 2 button, 3 BIOS load
	task automatic drive_inputs(input int req);
		aspect_ratio = 2'($urandom_range(3));
		scale        = 2'($urandom_range(3));
		mda_select   = 1'($urandom_range(1));
		port_b       = 8'($urandom);
		// Menu speed moves now and then
		if ($urandom_range(7) == 0)
			speed_field = 2'($urandom_range(3));
		bus_done     = ($urandom_range(15) == 0);
		menu_reset   = (req == 1);
		user_button  = (req == 2);
		bios_loading = (req == 3);
	endtask

	task automatic run_cycle(input int req);
		@(posedge CLK_50M);
		step_model();
		@(negedge CLK_50M);
		compare_outputs();
		drive_inputs(req);
	endtask

	always @(posedge CLK_50M) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("** FAIL **");
			$fatal(1, "Simulation timed out");
		end
	end

	// Bound checker assertions end the run at their first failure
	always @(dut.u_checker.failures) begin
		if (dut.u_checker.failures != 0) begin
			$display("Assertion failure in the bound checker");
			$display("** FAIL **");
			$fatal(1, "Checker assertion failed");
		end
	end

	initial begin
		menu_reset   = 1'b0;
		user_button  = 1'b0;
		bios_loading = 1'b0;
		bus_done     = 1'b0;
		aspect_ratio = 2'd0;
		scale        = 2'd0;
		mda_select   = 1'b0;
		speed_field  = 2'd0;
		port_b       = 8'd0;
		void'($urandom(32'h76f1db56));
		@(negedge CLK_50M);
		check_value("sys_reset during power-on", sys_reset, 1'b1);
		check_value("cpu_reset during power-on", cpu_reset, 1'b1);
		@(negedge reset_wire);
		// Power-on sequence
		while (m_cpu)
			run_cycle(0);
		// Menu reset while running
		repeat ($urandom_range(100, 1)) run_cycle(0);
		run_cycle(1);
		run_cycle(0);
		// User button during the CPU wait
		while (m_sys)
			run_cycle(0);
		repeat ($urandom_range(40, 0)) run_cycle(0);
		run_cycle(2);
		run_cycle(0);
		while (m_cpu)
			run_cycle(0);
		// BIOS download while running
		repeat ($urandom_range(100, 1)) run_cycle(0);
		run_cycle(3);
		run_cycle(0);
		while (m_cpu)
			run_cycle(0);
		// Free run, speed changes and bus cycles
		repeat (random_cycles) run_cycle(0);
		check_value("audio_ce count", audio_pulses,
			longint'(audio_updates) * pcxt_pkg::audio_step / pcxt_pkg::clock_hz);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
design/pcxt_pkg.sv
design/reset_sequencer.sv
design/clock_enables.sv
design/core_config.sv
design/pcxt_control.sv
tb/tb_clock.sv
tb/pcxt_control_checker.sv
tb/pcxt_control_tb.sv
